// File: Makefile
SRCS := $(shell cat tiny_core.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_tiny_core: tiny_core.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_tiny_core -f tiny_core.f

run: obj_dir/Vtb_tiny_core tiny_core_trace.txt
	./obj_dir/Vtb_tiny_core | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: alu_exec.sv
`default_nettype none

module alu_exec
    import tiny_core_pkg::*;
(
    input  wire decoded_insn_t i_dec,
    input  wire word_t         i_x,
    input  wire word_t         i_y,
    output word_t              o_result
);

    word_t imm_ext;
    word_t opnd_o;
    word_t addend;
    word_t op_val;
    logic  reserved;
    logic  lt;
    logic  eq;
    logic  gt;

    assign imm_ext = {{(WORD_W - IMM_W){i_dec.imm[IMM_W-1]}}, i_dec.imm};

    // Kind 0 adds the immediate, kind 1 uses it as the operand
    assign opnd_o = i_dec.kind ? imm_ext : i_y;
    assign addend = i_dec.kind ? i_y     : imm_ext;

    assign lt = $signed(i_x) <  $signed(opnd_o);
    assign eq = i_x == opnd_o;
    assign gt = $signed(i_x) >  $signed(opnd_o);

    always_comb begin
        reserved = 1'b0;
        case (i_dec.op)
            OP_OR:   op_val = i_x | opnd_o;
            OP_AND:  op_val = i_x & opnd_o;
            OP_ADD:  op_val = i_x + opnd_o;
            OP_MUL:  op_val = i_x * opnd_o;             // Low word only
            OP_SHL:  op_val = i_x << opnd_o[4:0];
            OP_LT:   op_val = {WORD_W{lt}};             // True is all ones
            OP_EQ:   op_val = {WORD_W{eq}};
            OP_GT:   op_val = {WORD_W{gt}};
            OP_NAND: op_val = ~(i_x & opnd_o);
            OP_XOR:  op_val = i_x ^ opnd_o;
            OP_SUB:  op_val = i_x - opnd_o;
            OP_XNOR: op_val = i_x ^ ~opnd_o;
            OP_SHR:  op_val = i_x >> opnd_o[4:0];       // Logical shift
            default: begin
                op_val   = '0;
                reserved = 1'b1;
            end
        endcase
    end

    // Reserved opcodes yield zero without the addend
    assign o_result = reserved ? '0 : op_val + addend;

endmodule

`default_nettype wire

// File: core_control.sv
`default_nettype none

module core_control
    import tiny_core_pkg::*;
(
    input  wire                clk,
    input  wire                reset_n,
    input  wire                i_en,
    input  wire decoded_insn_t i_dec,
    input  wire word_t         i_result,
    input  wire word_t         i_z_val,
    input  wire word_t         i_mem_rdata,
    output word_t              o_pc,
    output word_t              o_next_pc,
    output logic               o_reg_we,
    output reg_idx_t           o_reg_idx,
    output word_t              o_reg_data,
    output mem_req_t           o_mem_req,
    output logic               o_halt
);

    core_state_t state_q;
    word_t       pc_q;
    word_t       next_pc;
    word_t       wb_data;
    logic        active;
    logic        is_wb;
    logic        is_store;
    logic        jump;

    // Instruction retires only on an enabled edge while running
    assign active = i_en && (state_q == CORE_RUN);

    assign next_pc = pc_q + 32'd1;

    assign is_wb    = i_dec.valid && (i_dec.mode == MODE_REG || i_dec.mode == MODE_LOAD);
    assign is_store = i_dec.valid && (i_dec.mode == MODE_STORE_Z ||
                                      i_dec.mode == MODE_STORE_R);

    assign wb_data = (i_dec.mode == MODE_LOAD) ? i_mem_rdata : i_result;
    assign jump    = is_wb && (i_dec.z == REG_P);

    // Memory request from the mode
    always_comb begin
        case (i_dec.mode)
            MODE_STORE_Z: begin
                o_mem_req.addr  = i_z_val;     // [Z] <- result
                o_mem_req.wdata = i_result;
            end
            MODE_STORE_R: begin
                o_mem_req.addr  = i_result;    // [result] <- Z
                o_mem_req.wdata = i_z_val;
            end
            default: begin
                o_mem_req.addr  = i_result;    // Load address in mode 01
                o_mem_req.wdata = i_result;
            end
        endcase
        o_mem_req.we = active && is_store;
    end

    // The register file drops writes to index 0 and P
    assign o_reg_we   = active && is_wb;
    assign o_reg_idx  = i_dec.z;
    assign o_reg_data = wb_data;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state_q <= CORE_RUN;
            pc_q    <= RESET_VECTOR;
        end else if (active) begin
            if (i_dec.illegal) begin
                state_q <= CORE_HALTED;   // PC stays on the illegal word
            end else if (jump) begin
                pc_q <= wb_data;
            end else begin
                pc_q <= next_pc;
            end
        end
    end

    assign o_pc      = pc_q;
    assign o_next_pc = next_pc;
    assign o_halt    = (state_q == CORE_HALTED);

endmodule

`default_nettype wire

// File: insn_decode.sv
`default_nettype none

module insn_decode
    import tiny_core_pkg::*;
(
    input  wire word_t         i_insn,
    output decoded_insn_t      o_dec
);

    logic is_op;
    logic is_illegal;

    assign is_op      = ~i_insn[31];      // Top bit clear means operation
    assign is_illegal = &i_insn[31:28];   // All-ones top nibble

    always_comb begin
        o_dec = '0;
        if (is_op) begin
            o_dec.kind  = i_insn[KIND_BIT];
            o_dec.mode  = i_insn[MODE_LSB +: MODE_W];
            o_dec.z     = i_insn[Z_LSB +: REG_IDX_W];
            o_dec.x     = i_insn[X_LSB +: REG_IDX_W];
            o_dec.y     = i_insn[Y_LSB +: REG_IDX_W];
            o_dec.op    = i_insn[OP_LSB +: OP_W];
            o_dec.imm   = i_insn[IMM_LSB +: IMM_W];
            o_dec.valid = 1'b1;
        end else if (is_illegal) begin
            o_dec.illegal = 1'b1;
        end
        // Any other word stays all zero and acts as a no-op
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file
    import tiny_core_pkg::*;
(
    input  wire            clk,
    input  wire            reset_n,
    input  wire reg_idx_t  i_x_idx,
    input  wire reg_idx_t  i_y_idx,
    input  wire reg_idx_t  i_z_idx,
    input  wire word_t     i_next_pc,
    input  wire            i_we,
    input  wire reg_idx_t  i_w_idx,
    input  wire word_t     i_w_data,
    output word_t          o_x_val,
    output word_t          o_y_val,
    output word_t          o_z_val
);

    // Index 0 is constant and P sits in core_control
    word_t regs [1:14];

    function automatic word_t read_reg(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (idx == REG_P)
            val = i_next_pc;          // P reads as the next address
        else
            val = regs[idx];
        return val;
    endfunction

    assign o_x_val = read_reg(i_x_idx);
    assign o_y_val = read_reg(i_y_idx);
    assign o_z_val = read_reg(i_z_idx);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_w_idx != '0 && i_w_idx != REG_P) begin
            regs[i_w_idx] <= i_w_data;
        end
    end

endmodule

`default_nettype wire

// File: tb_tiny_core.sv
`default_nettype none

module tb_tiny_core
    import tiny_core_pkg::*;
();

    logic     clk = 1'b0;
    logic     reset_n = 1'b1;
    logic     en = 1'b0;
    word_t    insn_addr;
    word_t    insn_data = '0;
    mem_req_t mem_req;
    word_t    mem_rdata = '0;
    logic     halt;

    word_t    imem [word_t];
    word_t    dmem [word_t];
    word_t    exp_addr_q [$];       // Expected stores in program order
    word_t    exp_data_q [$];
    word_t    halt_addr = '0;
    logic     trace_loaded = 1'b0;
    int       mem_writes = 0;
    int       n_prog = 0;
    int       cycles = 0;
    int       limit = 0;
    integer   seed = 32'h8015;

    int       value_errs = 0;
    int       store_errs = 0;
    int       other_errs = 0;
    int       timeouts = 0;

    tiny_core i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_en        (en),
        .o_insn_addr (insn_addr),
        .i_insn_data (insn_data),
        .o_mem_req   (mem_req),
        .i_mem_rdata (mem_rdata),
        .o_halt      (halt)
    );

    always #2 clk = ~clk;

    // Data memory write and random enable on the rising edge
    always @(posedge clk) begin
        if (mem_req.we) begin
            dmem[mem_req.addr] = mem_req.wdata;
            mem_writes <= mem_writes + 1;
        end
        en <= (($random(seed) & 3) != 0);   // High about three cycles in four
    end

    function automatic word_t fetch_word(input word_t addr);
        word_t w;
        if (imem.exists(addr))
            w = imem[addr];
        else
            w = 32'hF000_0000;            // Unknown address halts the core
        return w;
    endfunction

    function automatic word_t read_data(input word_t addr);
        word_t w;
        if (dmem.exists(addr))
            w = dmem[addr];
        else
            w = addr ^ 32'h5A5A_C3C3;
        return w;
    endfunction

    always @(insn_addr or trace_loaded) insn_data = fetch_word(insn_addr);
    always @(mem_req or mem_writes or trace_loaded) mem_rdata = read_data(mem_req.addr);

    task automatic load_trace();
        int    fd;
        int    n;
        string tag;
        string line;
        word_t a;
        word_t d;
        fd = $fopen("tiny_core_trace.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open tiny_core_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1)
                break;
            if (tag == "#") begin
                n = $fgets(line, fd);     // Rest of a comment line
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h %h", a, d);
                imem[a] = d;
                n_prog++;
            end else if (tag == "D") begin
                n = $fscanf(fd, "%h %h", a, d);
                dmem[a] = d;
            end else if (tag == "S") begin
                n = $fscanf(fd, "%h %h", a, d);
                exp_addr_q.push_back(a);
                exp_data_q.push_back(d);
            end else if (tag == "H") begin
                n = $fscanf(fd, "%h", a);
                halt_addr = a;
            end else begin
                other_errs++;
                $display("unknown record %s in the trace file", tag);
            end
        end
        $fclose(fd);
        trace_loaded = 1'b1;
    endtask

    task automatic check_store();
        word_t exp_addr;
        word_t exp_data;
        if (mem_req.we) begin
            assert (en && !halt) else begin
                other_errs++;
                $display("store requested while stalled or halted");
            end
            assert (exp_addr_q.size() != 0) else begin
                store_errs++;
                $display("unexpected store of %h to %h", mem_req.wdata, mem_req.addr);
            end
            if (exp_addr_q.size() != 0) begin
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (mem_req.addr == exp_addr && mem_req.wdata == exp_data) else begin
                    store_errs++;
                    $display("ERR t=%0t: store %h <- %h, expected %h <- %h",
                             $time, mem_req.addr, mem_req.wdata, exp_addr, exp_data);
                end
            end
        end
    endtask

    // One clock from falling edge to falling edge
    task automatic step_cycle();
        word_t addr_before;
        word_t insn_before;
        word_t expected;
        logic  en_before;
        logic  halt_before;
        logic  jump;
        check_store();
        addr_before = insn_addr;
        insn_before = insn_data;
        en_before   = en;
        halt_before = halt;
        jump = !insn_before[31] && !insn_before[29] && insn_before[27:24] == 4'hF;
        @(negedge clk);
        cycles++;
        if (!en_before || halt_before || insn_before[31:28] == 4'hF)
            expected = addr_before;
        else
            expected = addr_before + 32'd1;
        // Jump targets show up through the stores that follow
        if (!jump || !en_before || halt_before) begin
            assert (insn_addr == expected) else begin
                value_errs++;
                $display("ERR t=%0t: fetch address %h after %h, expected %h",
                         $time, insn_addr, addr_before, expected);
            end
        end
        if (en_before && !halt_before && insn_before[31:28] == 4'hF) begin
            assert (halt) else begin
                other_errs++;
                $display("illegal word at %h did not halt the core", addr_before);
            end
        end
    endtask

    task automatic report_and_finish();
        int total;
        total = value_errs + store_errs + other_errs + timeouts;
        $display("errors: %0d value, %0d store, %0d other, %0d timeout after %0d cycles",
                 value_errs, store_errs, other_errs, timeouts, cycles);
        if (total == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    initial begin
        load_trace();
        limit = 8 * n_prog + 64;
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;
        @(negedge clk);
        assert (insn_addr == RESET_VECTOR) else begin
            value_errs++;
            $display("ERR t=%0t: fetch address %h after reset, expected %h",
                     $time, insn_addr, RESET_VECTOR);
        end
        assert (!mem_req.we && !halt) else begin
            other_errs++;
            $display("write strobe or halt active right after reset");
        end
        while (!halt && cycles < limit)
            step_cycle();
        if (!halt) begin
            timeouts++;
            $display("timeout: core did not halt");
        end else begin
            repeat (8) step_cycle();      // Halted core must stay put
            assert (insn_addr == halt_addr) else begin
                value_errs++;
                $display("ERR t=%0t: halted at %h, expected %h", $time, insn_addr, halt_addr);
            end
        end
        assert (exp_addr_q.size() == 0) else begin
            other_errs++;
            $display("%0d expected stores never happened", exp_addr_q.size());
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: tiny_core.f
tiny_core_pkg.sv
insn_decode.sv
alu_exec.sv
reg_file.sv
core_control.sv
tiny_core.sv
tb_tiny_core.sv

// File: tiny_core.sv
`default_nettype none

module tiny_core
    import tiny_core_pkg::*;
(
    input  wire            clk,
    input  wire            reset_n,
    input  wire            i_en,
    output word_t          o_insn_addr,
    input  wire word_t     i_insn_data,
    output mem_req_t       o_mem_req,
    input  wire word_t     i_mem_rdata,
    output logic           o_halt
);

    decoded_insn_t dec;
    word_t         x_val;
    word_t         y_val;
    word_t         z_val;
    word_t         result;
    word_t         next_pc;
    logic          reg_we;
    reg_idx_t      reg_idx;
    word_t         reg_data;

    insn_decode u_decode (
        .i_insn   (i_insn_data),
        .o_dec    (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_x_idx  (dec.x),
        .i_y_idx  (dec.y),
        .i_z_idx  (dec.z),
        .i_next_pc(next_pc),
        .i_we     (reg_we),
        .i_w_idx  (reg_idx),
        .i_w_data (reg_data),
        .o_x_val  (x_val),
        .o_y_val  (y_val),
        .o_z_val  (z_val)
    );

    alu_exec u_exec (
        .i_dec    (dec),
        .i_x      (x_val),
        .i_y      (y_val),
        .o_result (result)
    );

    // Fetch address is the PC held in control
    core_control u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_en        (i_en),
        .i_dec       (dec),
        .i_result    (result),
        .i_z_val     (z_val),
        .i_mem_rdata (i_mem_rdata),
        .o_pc        (o_insn_addr),
        .o_next_pc   (next_pc),
        .o_reg_we    (reg_we),
        .o_reg_idx   (reg_idx),
        .o_reg_data  (reg_data),
        .o_mem_req   (o_mem_req),
        .o_halt      (o_halt)
    );

endmodule

`default_nettype wire

// File: tiny_core_pkg.sv
`default_nettype none

package tiny_core_pkg;

    // Basic widths
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 12;
    localparam int OP_W      = 4;
    localparam int MODE_W    = 2;

    // Instruction word layout
    localparam int KIND_BIT = 30;
    localparam int MODE_LSB = 28;
    localparam int Z_LSB    = 24;
    localparam int X_LSB    = 20;
    localparam int Y_LSB    = 16;
    localparam int OP_LSB   = 12;
    localparam int IMM_LSB  = 0;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [OP_W-1:0]      opcode_t;
    typedef logic [MODE_W-1:0]    mode_t;

    localparam word_t    RESET_VECTOR = 32'h0000_0100;
    localparam reg_idx_t REG_P        = 4'd15; // Program counter

    // Opcodes 4, 14 and 15 are reserved
    localparam opcode_t OP_OR   = 4'd0;
    localparam opcode_t OP_AND  = 4'd1;
    localparam opcode_t OP_ADD  = 4'd2;
    localparam opcode_t OP_MUL  = 4'd3;
    localparam opcode_t OP_SHL  = 4'd5;
    localparam opcode_t OP_LT   = 4'd6;
    localparam opcode_t OP_EQ   = 4'd7;
    localparam opcode_t OP_GT   = 4'd8;
    localparam opcode_t OP_NAND = 4'd9;
    localparam opcode_t OP_XOR  = 4'd10;
    localparam opcode_t OP_SUB  = 4'd11;
    localparam opcode_t OP_XNOR = 4'd12;
    localparam opcode_t OP_SHR  = 4'd13;

    // Memory modes
    localparam mode_t MODE_REG     = 2'b00; //  Z  <-  result
    localparam mode_t MODE_LOAD    = 2'b01; //  Z  <- [result]
    localparam mode_t MODE_STORE_Z = 2'b10; // [Z] <-  result
    localparam mode_t MODE_STORE_R = 2'b11; // [result] <- Z

    typedef struct packed {
        reg_idx_t z;
        reg_idx_t x;
        reg_idx_t y;
        imm_t     imm;
        opcode_t  op;
        mode_t    mode;
        logic     kind;    // Set when the immediate is the operand O
        logic     valid;
        logic     illegal;
    } decoded_insn_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef enum logic [0:0] {
        CORE_RUN,
        CORE_HALTED
    } core_state_t;

endpackage

`default_nettype wire

// File: tiny_core_trace.txt
# P insn_addr insn_word | D data_addr data_word | S store_addr store_data | H halt_addr
# All values hex, S records in program order, a P and its S may share a line
D 00000080 CAFEF00D
D 00000081 12345678
# r1 = 12, r2 = -10, r3 = 0x40, r4 = 0x41
P 00000100 0100000C
P 00000101 02000FF6
P 00000102 03000040
P 00000103 04000041
# Kind 0, op(r1, r2) + 16 stored at [r3]
P 00000104 23120010  S 00000040 0000000E
P 00000105 23121010  S 00000040 00000014
P 00000106 23122010  S 00000040 00000012
P 00000107 23123010  S 00000040 FFFFFF98
P 00000108 23125010  S 00000040 03000010
P 00000109 23126010  S 00000040 00000010
P 0000010A 23127010  S 00000040 00000010
P 0000010B 23128010  S 00000040 0000000F
P 0000010C 23129010  S 00000040 0000000B
P 0000010D 2312A010  S 00000040 0000000A
P 0000010E 2312B010  S 00000040 00000026
P 0000010F 2312C010  S 00000040 00000015
P 00000110 2312D010  S 00000040 00000010
# Kind 1, op(r2, 33) + r1 stored at [r4]
P 00000111 64210021  S 00000041 00000003
P 00000112 64211021  S 00000041 0000002C
P 00000113 64212021  S 00000041 00000023
P 00000114 64213021  S 00000041 FFFFFEC2
P 00000115 64215021  S 00000041 FFFFFFF8
P 00000116 64216021  S 00000041 0000000B
P 00000117 64217021  S 00000041 0000000C
P 00000118 64218021  S 00000041 0000000C
P 00000119 64219021  S 00000041 FFFFFFEB
P 0000011A 6421A021  S 00000041 FFFFFFE3
P 0000011B 6421B021  S 00000041 FFFFFFE1
P 0000011C 6421C021  S 00000041 00000034
P 0000011D 6421D021  S 00000041 80000007
# Loads into r5 and r6, then stores of Z at the result address
P 0000011E 15000080
P 0000011F 16302041
P 00000120 35000090  S 00000090 CAFEF00D
P 00000121 76412010  S 0000005D 12345678
# Jump over two stores, then store the value of P
P 00000122 0F000125
P 00000123 23000BAD
P 00000124 24000BAD
P 00000125 23F00000  S 00000040 00000126
# Ignored word, then the illegal word
P 00000126 80000000
P 00000127 F0000000
H 00000127
